// File: design/gb_io_top.sv
// I/O register block of the system bus, cpu side
// decoder, interrupt controller, timer, serial, joypad and zero page
`timescale 1ns/1ps

module gb_io_top (
	input  logic                        clk_cpu,
	input  logic                        reset,
	input  gb_map_pkg::addr_t           cpu_addr,
	input  logic                        cpu_wr,
	input  gb_map_pkg::data_t           cpu_wdata,
	output gb_map_pkg::data_t           cpu_rdata,
	input  logic                        irq_ack,
	output logic                        irq_n,
	input  gb_periph_pkg::joy_buttons_t buttons
);
	import gb_map_pkg::*;

	data_t ack_vector;
	logic  timer_irq;   // one cycle pulses into IF
	logic  serial_irq;
	logic  joy_irq;

	// --------------------
	// device buses
	io_bus_if bus_irq ();
	io_bus_if bus_tmr ();
	io_bus_if bus_ser ();
	io_bus_if bus_joy ();
	io_bus_if bus_zp ();

	io_decode u_decode (.cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_wdata(cpu_wdata),
		.irq_ack(irq_ack), .ack_vector(ack_vector), .cpu_rdata(cpu_rdata),
		.irq(bus_irq), .tmr(bus_tmr), .ser(bus_ser), .joy(bus_joy), .zp(bus_zp));

	interrupt_ctrl u_irq (.clk_cpu(clk_cpu), .reset(reset), .bus(bus_irq),
		.timer_irq(timer_irq), .serial_irq(serial_irq), .joy_irq(joy_irq),
		.irq_ack(irq_ack), .irq_n(irq_n), .ack_vector(ack_vector));

	timer u_timer (.clk_cpu(clk_cpu), .reset(reset), .bus(bus_tmr), .irq(timer_irq));

	serial_port u_serial (.clk_cpu(clk_cpu), .reset(reset), .bus(bus_ser), .irq(serial_irq));

	joypad u_joypad (.clk_cpu(clk_cpu), .reset(reset), .bus(bus_joy), .buttons(buttons),
		.irq(joy_irq));

	zero_page_ram u_zp (.clk_cpu(clk_cpu), .bus(bus_zp));

endmodule

// File: design/gb_map_pkg.sv
// CPU memory map of the high I/O page
// bus types and fixed register addresses shared by decode and devices
package gb_map_pkg;

	typedef logic [15:0] addr_t;     // full cpu address
	typedef logic [7:0]  data_t;     // one bus byte
	typedef logic [7:0]  reg_off_t;  // low address byte seen by a device
	typedef logic [6:0]  zp_addr_t;  // zero page index

	// --------------------
	// fixed registers
	localparam addr_t ADDR_JOYP = 16'hFF00;
	localparam addr_t ADDR_SB   = 16'hFF01;
	localparam addr_t ADDR_SC   = 16'hFF02;
	localparam addr_t ADDR_DIV  = 16'hFF04;  // timer block starts here, 4 regs
	localparam addr_t ADDR_TIMA = 16'hFF05;
	localparam addr_t ADDR_TMA  = 16'hFF06;
	localparam addr_t ADDR_TAC  = 16'hFF07;
	localparam addr_t ADDR_IF   = 16'hFF0F;
	localparam addr_t ADDR_IE   = 16'hFFFF;

	localparam addr_t ZP_BASE = 16'hFF80;  // zero page window
	localparam addr_t ZP_LAST = 16'hFFFE;  // IE sits just above

	localparam data_t OPEN_BUS = 8'hFF;    // unmapped read value

endpackage

// File: design/gb_periph_pkg.sv
// peripheral constants for interrupts, timer, serial and joypad
package gb_periph_pkg;

	// --------------------
	// interrupts
	typedef logic [4:0] irq_vec_t;  // IF / IE mask, bit 0 has top priority

	localparam logic [2:0] IRQ_VBLANK = 3'd0;
	localparam logic [2:0] IRQ_LCD    = 3'd1;
	localparam logic [2:0] IRQ_TIMER  = 3'd2;
	localparam logic [2:0] IRQ_SERIAL = 3'd3;
	localparam logic [2:0] IRQ_JOYPAD = 3'd4;

	localparam logic [7:0] VEC_BASE = 8'h40;  // rst vector of bit 0
	localparam logic [7:0] VEC_STEP = 8'h08;
	localparam logic [7:0] VEC_NONE = 8'h55;  // ack with nothing pending

	// --------------------
	// timer
	typedef logic [15:0] div_t;
	localparam int TAC_EN_BIT = 2;
	localparam int TAP_1024   = 9;  // divider bits feeding TIMA per rate
	localparam int TAP_16     = 3;
	localparam int TAP_64     = 5;
	localparam int TAP_256    = 7;

	// serial, internal clock only
	localparam int SERIAL_BIT_CYCLES = 512;
	localparam int SERIAL_BITS       = 8;
	localparam int SERIAL_CYC_W      = $clog2(SERIAL_BIT_CYCLES);
	localparam int SERIAL_BIT_W      = $clog2(SERIAL_BITS);

	// joypad, pressed = 1
	typedef logic [7:0] joy_buttons_t;  // start select b a down up left right
	localparam int JOY_DIR_SEL = 4;     // P14, low enables directions
	localparam int JOY_BTN_SEL = 5;     // P15, low enables buttons

endpackage

// File: design/interrupt_ctrl.sv
// interrupt flag and enable registers
// sets flags from source pulses, clears the top pending one on ack
`timescale 1ns/1ps

module interrupt_ctrl (
	input  logic              clk_cpu,
	input  logic              reset,
	io_bus_if.device          bus,
	input  logic              timer_irq,
	input  logic              serial_irq,
	input  logic              joy_irq,
	input  logic              irq_ack,
	output logic              irq_n,
	output gb_map_pkg::data_t ack_vector
);
	import gb_map_pkg::*;
	import gb_periph_pkg::*;

	irq_vec_t   if_r;      // FF0F
	irq_vec_t   ie_r;      // FFFF
	irq_vec_t   src;       // one cycle set pulses
	irq_vec_t   pending;
	irq_vec_t   clr_mask;
	logic [2:0] ack_idx;
	logic       ack_hit;
	logic       wr_if;
	logic       wr_ie;

	assign wr_if = bus.sel && bus.wr && (bus.addr == ADDR_IF[7:0]);
	assign wr_ie = bus.sel && bus.wr && (bus.addr == ADDR_IE[7:0]);

	assign pending = if_r & ie_r;
	assign irq_n   = ~|pending;  // low while anything enabled is pending

	always_comb begin
		src[IRQ_VBLANK] = 1'b0;  // no video here, cpu write only
		src[IRQ_LCD]    = 1'b0;
		src[IRQ_TIMER]  = timer_irq;
		src[IRQ_SERIAL] = serial_irq;
		src[IRQ_JOYPAD] = joy_irq;
	end

	// lowest index wins, so scan downwards
	always_comb begin
		ack_hit = 1'b0;
		ack_idx = '0;
		for (int i = $bits(irq_vec_t) - 1; i >= 0; i--) begin
			if (pending[i]) begin
				ack_hit = 1'b1;
				ack_idx = 3'(i);
			end
		end
	end

	assign clr_mask   = (irq_ack && ack_hit) ? (irq_vec_t'(1) << ack_idx) : '0;
	assign ack_vector = ack_hit ? VEC_BASE + VEC_STEP * data_t'(ack_idx) : VEC_NONE;

	assign bus.rdata = (bus.addr == ADDR_IE[7:0]) ? {3'b000, ie_r} : {3'b111, if_r};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r <= '0;
			ie_r <= '0;
		end else begin
			if (wr_if)
				if_r <= bus.wdata[4:0];          // cpu write replaces all flags
			else
				if_r <= (if_r | src) & ~clr_mask; // ack clear beats a new pulse
			if (wr_ie)
				ie_r <= bus.wdata[4:0];
		end
	end

endmodule

// File: design/io_bus_if.sv
// register bus between the I/O decoder and one device
// single cycle, write on the clock edge, read in the same cycle
`timescale 1ns/1ps

interface io_bus_if;

	logic                  sel;    // decode hit for this device
	logic                  wr;     // write strobe, qualified by sel
	gb_map_pkg::reg_off_t  addr;   // low address byte
	gb_map_pkg::data_t     wdata;
	gb_map_pkg::data_t     rdata;  // combinational from the device

	modport host (output sel, wr, addr, wdata, input rdata);

	modport device (input sel, wr, addr, wdata, output rdata);

endinterface

// File: design/io_decode.sv
// high page address decoder
// one select per device, read mux with vector and open-bus fallback
`timescale 1ns/1ps

module io_decode (
	input  gb_map_pkg::addr_t cpu_addr,
	input  logic              cpu_wr,
	input  gb_map_pkg::data_t cpu_wdata,
	input  logic              irq_ack,
	input  gb_map_pkg::data_t ack_vector,
	output gb_map_pkg::data_t cpu_rdata,
	io_bus_if.host            irq,
	io_bus_if.host            tmr,
	io_bus_if.host            ser,
	io_bus_if.host            joy,
	io_bus_if.host            zp
);
	import gb_map_pkg::*;

	// --------------------
	// address compare
	assign joy.sel = (cpu_addr == ADDR_JOYP);
	assign ser.sel = (cpu_addr == ADDR_SB) || (cpu_addr == ADDR_SC);
	assign tmr.sel = (cpu_addr[15:2] == ADDR_DIV[15:2]);  // FF04..FF07
	assign irq.sel = (cpu_addr == ADDR_IF) || (cpu_addr == ADDR_IE);
	assign zp.sel  = (cpu_addr >= ZP_BASE) && (cpu_addr <= ZP_LAST);  // excludes IE

	// devices only see the low byte
	assign irq.addr  = cpu_addr[7:0];
	assign irq.wr    = cpu_wr;
	assign irq.wdata = cpu_wdata;
	assign tmr.addr  = cpu_addr[7:0];
	assign tmr.wr    = cpu_wr;
	assign tmr.wdata = cpu_wdata;
	assign ser.addr  = cpu_addr[7:0];
	assign ser.wr    = cpu_wr;
	assign ser.wdata = cpu_wdata;
	assign joy.addr  = cpu_addr[7:0];
	assign joy.wr    = cpu_wr;
	assign joy.wdata = cpu_wdata;
	assign zp.addr   = cpu_addr[7:0];
	assign zp.wr     = cpu_wr;
	assign zp.wdata  = cpu_wdata;

	// --------------------
	// read data
	always_comb begin
		if (irq_ack)
			cpu_rdata = ack_vector;   // ack cycle overrides the address
		else if (irq.sel)
			cpu_rdata = irq.rdata;
		else if (tmr.sel)
			cpu_rdata = tmr.rdata;
		else if (ser.sel)
			cpu_rdata = ser.rdata;
		else if (joy.sel)
			cpu_rdata = joy.rdata;
		else if (zp.sel)
			cpu_rdata = zp.rdata;
		else
			cpu_rdata = OPEN_BUS;     // nothing mapped here
	end

endmodule

// File: design/joypad.sv
// joypad register FF00
// group select, matrix read value, falling edge interrupt
`timescale 1ns/1ps

module joypad (
	input  logic                        clk_cpu,
	input  logic                        reset,
	io_bus_if.device                    bus,
	input  gb_periph_pkg::joy_buttons_t buttons,
	output logic                        irq
);
	import gb_periph_pkg::*;

	logic [1:0] p54;       // {P15, P14}, 0 enables the group
	logic [3:0] dir_n;
	logic [3:0] btn_n;
	logic [3:0] lines;     // P10..P13, low = pressed
	logic [3:0] lines_q1;  // sampler stage 1
	logic [3:0] lines_q2;

	assign dir_n = ~buttons[3:0] | {4{p54[0]}};  // down up left right
	assign btn_n = ~buttons[7:4] | {4{p54[1]}};  // start select b a
	assign lines = dir_n & btn_n;

	assign bus.rdata = {2'b11, p54, lines};
	assign irq       = |(lines_q2 & ~lines_q1);  // any line went low

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54      <= 2'b00;
			lines_q1 <= 4'hF;  // released
			lines_q2 <= 4'hF;
		end else begin
			if (bus.sel && bus.wr)
				p54 <= {bus.wdata[JOY_BTN_SEL], bus.wdata[JOY_DIR_SEL]};
			lines_q1 <= lines;
			lines_q2 <= lines_q1;
		end
	end

endmodule

// File: design/serial_port.sv
// serial control with no link partner
// times an 8 bit transfer on the internal clock, then raises its irq
`timescale 1ns/1ps

module serial_port (
	input  logic     clk_cpu,
	input  logic     reset,
	io_bus_if.device bus,
	output logic     irq
);
	import gb_map_pkg::*;
	import gb_periph_pkg::*;

	typedef enum logic [1:0] {IDLE, SHIFT, DONE} ser_state_t;

	ser_state_t              state;
	logic                    sc_start;    // SC bit 7
	logic                    sc_int_clk;  // SC bit 0
	logic [SERIAL_BIT_W-1:0] bit_cnt;
	logic [SERIAL_CYC_W-1:0] cyc_cnt;
	logic                    wr_sc;

	assign wr_sc = bus.sel && bus.wr && (bus.addr == ADDR_SC[7:0]);
	assign irq   = (state == DONE);  // single cycle, bit 7 drops at its edge

	// SB idles high, nothing shifts in
	assign bus.rdata = (bus.addr == ADDR_SB[7:0]) ? 8'hFF : {sc_start, 6'h3F, sc_int_clk};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state      <= IDLE;
			sc_start   <= 1'b0;
			sc_int_clk <= 1'b0;
			bit_cnt    <= '0;
			cyc_cnt    <= '0;
		end else if (wr_sc) begin
			sc_start   <= bus.wdata[7];
			sc_int_clk <= bus.wdata[0];
			bit_cnt    <= '0;
			cyc_cnt    <= '0;
			// external clock never comes, so only internal clock starts
			state      <= (bus.wdata[7] && bus.wdata[0]) ? SHIFT : IDLE;
		end else begin
			case (state)
				SHIFT: begin
					cyc_cnt <= cyc_cnt + 1'b1;  // wraps once per bit
					if (cyc_cnt == SERIAL_CYC_W'(SERIAL_BIT_CYCLES - 1)) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == SERIAL_BIT_W'(SERIAL_BITS - 1))
							state <= DONE;
					end
				end
				DONE: begin
					sc_start <= 1'b0;  // transfer finished
					state    <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: design/timer.sv
// divider and timer block, FF04..FF07
// free running DIV, TIMA clocked by a divider tap, reload from TMA
`timescale 1ns/1ps

module timer (
	input  logic     clk_cpu,
	input  logic     reset,
	io_bus_if.device bus,
	output logic     irq
);
	import gb_map_pkg::*;
	import gb_periph_pkg::*;

	div_t       div_cnt;
	data_t      tima;
	data_t      tma;
	logic [2:0] tac;      // enable, rate[1:0]
	logic       tap;
	logic       tap_en;
	logic       tap_q;
	logic       tick;
	logic       wr_div;
	logic       wr_tima;
	logic       wr_tma;
	logic       wr_tac;

	assign wr_div  = bus.sel && bus.wr && (bus.addr == ADDR_DIV[7:0]);
	assign wr_tima = bus.sel && bus.wr && (bus.addr == ADDR_TIMA[7:0]);
	assign wr_tma  = bus.sel && bus.wr && (bus.addr == ADDR_TMA[7:0]);
	assign wr_tac  = bus.sel && bus.wr && (bus.addr == ADDR_TAC[7:0]);

	// --------------------
	// tap select and falling edge
	always_comb begin
		case (tac[1:0])
			2'd0:    tap = div_cnt[TAP_1024];
			2'd1:    tap = div_cnt[TAP_16];
			2'd2:    tap = div_cnt[TAP_64];
			default: tap = div_cnt[TAP_256];
		endcase
	end

	assign tap_en = tap && tac[TAC_EN_BIT];
	assign tick   = tap_q && !tap_en;
	assign irq    = tick && (tima == 8'hFF);  // same edge as the reload

	always_comb begin
		case (bus.addr)
			ADDR_DIV[7:0]:  bus.rdata = div_cnt[15:8];
			ADDR_TIMA[7:0]: bus.rdata = tima;
			ADDR_TMA[7:0]:  bus.rdata = tma;
			default:        bus.rdata = {5'b11111, tac};  // TAC
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			div_cnt <= '0;
			tima    <= '0;
			tma     <= '0;
			tac     <= '0;
			tap_q   <= 1'b0;
		end else begin
			div_cnt <= wr_div ? '0 : div_cnt + 1'b1;  // any write zeroes
			tap_q   <= tap_en;
			if (wr_tima)
				tima <= bus.wdata;
			else if (tick)
				tima <= irq ? tma : tima + 1'b1;
			if (wr_tma)
				tma <= bus.wdata;
			if (wr_tac)
				tac <= bus.wdata[2:0];
		end
	end

endmodule

// File: design/zero_page_ram.sv
// zero page RAM, FF80..FFFE
// 127 byte register file, clocked write, combinational read
`timescale 1ns/1ps

module zero_page_ram (
	input  logic     clk_cpu,
	io_bus_if.device bus
);
	import gb_map_pkg::*;

	data_t    mem [0:ZP_LAST[6:0]];  // last index 7E, FFFF belongs to IE
	zp_addr_t idx;

	assign idx       = bus.addr[6:0];
	assign bus.rdata = mem[idx];  // same cycle read

	always_ff @(posedge clk_cpu) begin
		if (bus.sel && bus.wr)
			mem[idx] <= bus.wdata;
	end

endmodule

// File: files.f
design/gb_map_pkg.sv
design/gb_periph_pkg.sv
design/io_bus_if.sv
design/io_decode.sv
design/interrupt_ctrl.sv
design/timer.sv
design/serial_port.sv
design/joypad.sv
design/zero_page_ram.sv
design/gb_io_top.sv
verif/gb_io_checker.sv
verif/gb_io_tb.sv

// File: verif/gb_io_checker.sv
// protocol checks for the I/O register block
// irq pulse width, request line against IF and IE, one device select
`timescale 1ns/1ps

module gb_io_checker (
	input logic                    clk_cpu,
	input logic                    reset,
	input logic                    timer_irq,
	input logic                    serial_irq,
	input logic                    irq_n,
	input gb_periph_pkg::irq_vec_t if_r,
	input gb_periph_pkg::irq_vec_t ie_r,
	input logic [4:0]              sels   // irq, tmr, ser, joy, zp
);

	int fail_count = 0;  // failed assertion count

	// --------------------
	// source pulses are one cycle
	a_timer_pulse: assert property (@(posedge clk_cpu) disable iff (reset)
		timer_irq |=> !timer_irq) else begin
		$error("timer irq held longer than one cycle");
		fail_count++;
	end

	a_serial_pulse: assert property (@(posedge clk_cpu) disable iff (reset)
		serial_irq |=> !serial_irq) else begin
		$error("serial irq held longer than one cycle");
		fail_count++;
	end

	// nothing enabled and pending means no request
	a_irq_idle: assert property (@(posedge clk_cpu) disable iff (reset)
		((if_r & ie_r) == '0) |-> irq_n) else begin
		$error("irq_n low with nothing pending");
		fail_count++;
	end

	a_one_sel: assert property (@(posedge clk_cpu) disable iff (reset)
		$onehot0(sels)) else begin
		$error("more than one device selected");
		fail_count++;
	end

endmodule

bind gb_io_top gb_io_checker u_check (.clk_cpu(clk_cpu), .reset(reset),
	.timer_irq(timer_irq), .serial_irq(serial_irq), .irq_n(irq_n),
	.if_r(u_irq.if_r), .ie_r(u_irq.ie_r),
	.sels({bus_irq.sel, bus_tmr.sel, bus_ser.sel, bus_joy.sel, bus_zp.sel}));

// File: verif/gb_io_tb.sv
// testbench for the I/O register block
// random bus traffic checked against a model of zero page, IE and IF
`timescale 1ns/1ps

module gb_io_tb;
	import gb_map_pkg::*;
	import gb_periph_pkg::*;

	// serial transfer takes about 4100 cycles and the rest stays well under 3000
	localparam int MAX_CYCLES = 20000;

	logic         clk_cpu;
	logic         reset;
	addr_t        cpu_addr;
	logic         cpu_wr;
	data_t        cpu_wdata;
	data_t        cpu_rdata;
	logic         irq_ack;
	logic         irq_n;
	joy_buttons_t buttons;

	integer   seed = 32'hc2271d65;
	int       errors;
	int       checks;
	int       cycles;
	data_t    zp_model [0:126];  // expected zero page bytes
	bit       zp_known [0:126];  // written at least once
	irq_vec_t if_m;              // model of FF0F
	irq_vec_t ie_m;              // model of FFFF

	gb_io_top UUT (.clk_cpu(clk_cpu), .reset(reset), .cpu_addr(cpu_addr), .cpu_wr(cpu_wr),
		.cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata), .irq_ack(irq_ack), .irq_n(irq_n),
		.buttons(buttons));

	initial begin
		clk_cpu = 1'b0;
		forever #2 clk_cpu = ~clk_cpu;  // 4 ns period
	end

	// --------------------
	// bus tasks
	task automatic step();
		@(posedge clk_cpu);
		#1;                             // inputs move just after the edge
	endtask

	task automatic bus_write(input addr_t a, input data_t d);
		cpu_addr  = a;
		cpu_wr    = 1'b1;
		cpu_wdata = d;
		step();                         // written at this edge
		cpu_wr    = 1'b0;
	endtask

	task automatic bus_read(input addr_t a, output data_t d);
		cpu_addr = a;
		@(negedge clk_cpu);             // read data settled by mid cycle
		d = cpu_rdata;
		step();
	endtask

	task automatic ack_irq(output data_t vec);
		irq_ack = 1'b1;
		@(negedge clk_cpu);
		vec = cpu_rdata;
		step();                         // flag clears at this edge
		irq_ack = 1'b0;
	endtask

	task automatic check_value(input string what, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at time %0t: %s read %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// lowest pending index picks the vector
	function automatic data_t vector_of(input irq_vec_t m);
		for (int i = 0; i < 5; i++)
			if (m[i])
				return VEC_BASE + VEC_STEP * data_t'(i);
		return VEC_NONE;
	endfunction

	// --------------------
	// test sequence
	initial begin
		data_t rd;
		data_t tma_v;
		addr_t a;
		int    idx;
		logic  got;

		errors    = 0;
		checks    = 0;
		reset     = 1'b1;
		cpu_addr  = '0;
		cpu_wr    = 1'b0;
		cpu_wdata = '0;
		irq_ack   = 1'b0;
		buttons   = '0;                 // all released
		repeat (16) @(posedge clk_cpu);
		#1 reset = 1'b0;

		// mixed zero page writes and reads
		for (int i = 0; i < 200; i++) begin
			idx = $unsigned($random(seed)) % 127;
			a   = ZP_BASE + addr_t'(idx);
			if ($random(seed) & 1) begin
				rd = data_t'($random(seed));
				bus_write(a, rd);
				zp_model[idx] = rd;
				zp_known[idx] = 1'b1;
			end else if (zp_known[idx]) begin
				bus_read(a, rd);
				check_value("zero page", rd, zp_model[idx]);
			end
		end
		for (int i = 0; i < 127; i++)
			if (zp_known[i]) begin
				bus_read(ZP_BASE + addr_t'(i), rd);
				check_value("zero page sweep", rd, zp_model[i]);
			end
		bus_read(16'hFF03, rd);         // hole next to the serial regs
		check_value("open bus FF03", rd, 8'hFF);
		bus_read(16'hFF50, rd);
		check_value("open bus FF50", rd, 8'hFF);

		// random IE and IF values with only the low 5 bits stored
		for (int i = 0; i < 40; i++) begin
			rd = data_t'($random(seed));
			bus_write(ADDR_IE, rd);
			ie_m = rd[4:0];
			rd = data_t'($random(seed));
			bus_write(ADDR_IF, rd);
			if_m = rd[4:0];
			bus_read(ADDR_IF, rd);
			check_value("IF", rd, {3'b111, if_m});
			bus_read(ADDR_IE, rd);
			check_value("IE", rd, {3'b000, ie_m});
			check_value("irq_n", irq_n, !(|(if_m & ie_m)));
		end

		// acknowledge walks the pending flags in priority order
		ie_m = 5'h1F;
		bus_write(ADDR_IE, 8'h1F);
		if_m = irq_vec_t'($random(seed)) | 5'b00101;  // at least two pending
		bus_write(ADDR_IF, {3'b000, if_m});
		while (if_m != 0) begin
			ack_irq(rd);
			check_value("ack vector", rd, vector_of(if_m));
			if_m = if_m & (if_m - 1'b1);                 // lowest set bit gone
			bus_read(ADDR_IF, rd);
			check_value("IF after ack", rd, {3'b111, if_m});
		end
		ack_irq(rd);
		check_value("empty ack vector", rd, VEC_NONE);

		// timer at rate 1 counts every 16 cycles
		bus_write(ADDR_IF, 8'h00);
		tma_v = data_t'($random(seed));
		bus_write(ADDR_TMA, tma_v);
		bus_write(ADDR_TIMA, 8'hFE);
		bus_write(ADDR_TAC, 8'h05);
		repeat (100) step();
		bus_read(ADDR_IF, rd);
		check_value("timer flag", rd[IRQ_TIMER], 1'b1);
		bus_read(ADDR_TIMA, rd);
		check_value("TIMA not below TMA", rd >= tma_v, 1'b1);
		bus_write(ADDR_TAC, 8'h00);     // stop it
		bus_write(ADDR_DIV, 8'hA5);     // any value clears
		bus_read(ADDR_DIV, rd);
		check_value("DIV after write", rd <= 8'd1, 1'b1);

		// serial with internal clock
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_SC, 8'h81);
		bus_read(ADDR_SC, rd);
		check_value("SC busy", rd[7], 1'b1);
		repeat (SERIAL_BITS * SERIAL_BIT_CYCLES + 10) step();
		bus_read(ADDR_SC, rd);
		check_value("SC done", rd[7], 1'b0);
		bus_read(ADDR_IF, rd);
		check_value("serial flag", rd[IRQ_SERIAL], 1'b1);

		// joypad with the directions selected
		bus_write(ADDR_JOYP, 8'h20);
		for (int i = 0; i < 20; i++) begin
			buttons = joy_buttons_t'($random(seed));
			bus_read(ADDR_JOYP, rd);
			check_value("JOYP", rd, {4'b1110, ~buttons[3:0]});
		end
		buttons = '0;
		repeat (3) step();              // let the sampler drain
		bus_write(ADDR_IF, 8'h00);
		buttons = joy_buttons_t'(1) << ($unsigned($random(seed)) % 4);
		got = 1'b0;
		for (int i = 0; i < 5 && !got; i++) begin
			bus_read(ADDR_IF, rd);
			got = rd[IRQ_JOYPAD];
		end
		check_value("joypad flag within 5 cycles", got, 1'b1);

		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			UUT.u_check.fail_count);
		if (errors == 0 && UUT.u_check.fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// run limit
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_cpu);
			cycles++;
		end
		$display("timeout: test sequence did not finish within %0d cycles", MAX_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
